//--- lcd_pkg.sv
package lcd_pkg;

	// display-mode bits, msb first
	typedef struct packed {
		logic lines;     // 1 = two lines
		logic font;      // 1 = 5x10 dots
		logic disp_on;
		logic cursor_on;
		logic blink;
		logic inc_dec;   // 1 = cursor moves right
		logic shift;     // shift display on write
	} mode_t;

	// one word on the lcd bus
	typedef struct packed {
		logic       rs;    // 1 = character data
		logic [7:0] data;
	} bus_word_t;

	localparam int bus_word_w = 9;

	// command opcode bases
	localparam logic [7:0] cmd_func_set   = 8'h30;
	localparam logic [7:0] cmd_disp_ctrl  = 8'h08;
	localparam logic [7:0] cmd_clear      = 8'h01;
	localparam logic [7:0] cmd_entry_mode = 8'h04;
	localparam logic [7:0] cmd_set_addr   = 8'h80;

	localparam logic [6:0] line2_addr = 7'h40;    // ddram start of line 2

	// timing in microseconds
	localparam int t_power_up   = 500;
	localparam int t_init_pulse = 10;    // e high per init command
	localparam int t_wait_func  = 50;
	localparam int t_wait_disp  = 50;
	localparam int t_wait_clear = 200;   // clear is the slow one
	localparam int t_wait_entry = 100;
	localparam int t_cmd_total  = 50;    // whole slot of one queued word
	localparam int t_e_rise     = 1;
	localparam int t_e_fall     = 14;

	localparam int line_cols = 16;

endpackage

//--- lcd_cfg_regs.sv
`timescale 1ns/1ps

module lcd_cfg_regs (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           cfg_we,
	input  lcd_pkg::mode_t cfg_wdata,
	input  logic           reinit_ack,
	output lcd_pkg::mode_t mode,
	output logic           reinit_req
);

	import lcd_pkg::*;

	// one line and 5x10 font with display on and a blinking cursor
	localparam mode_t mode_rst = 7'h3C;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode <= mode_rst;
		end else if (cfg_we) begin
			mode <= cfg_wdata;
		end
	end

	// a new write beats a same-cycle ack
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reinit_req <= 1'b1;    // init runs right after reset
		end else if (cfg_we) begin
			reinit_req <= 1'b1;
		end else if (reinit_ack) begin
			reinit_req <= 1'b0;
		end
	end

endmodule

//--- lcd_cmd_fifo.sv
`timescale 1ns/1ps

module lcd_cmd_fifo #(
	parameter int width = 9,
	parameter int depth = 8
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             wr_valid,
	output logic             wr_ready,
	input  logic [width-1:0] wr_data,
	output logic             rd_valid,
	input  logic             rd_ready,
	output logic [width-1:0] rd_data
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// wrap at depth, which need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign wr_ready = (count != cnt_w'(depth));
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];

	assign do_wr = wr_valid && wr_ready;
	assign do_rd = rd_valid && rd_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

//--- lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               init_start,
	input  logic               char_valid,
	output logic               char_ready,
	input  logic [7:0]         char_data,
	output logic               wr_valid,
	input  logic               wr_ready,
	output lcd_pkg::bus_word_t wr_word
);

	import lcd_pkg::*;

	logic       started;      // set once the display has been cleared
	logic       line;         // 0 = top line
	logic [4:0] col;          // 0 to line_cols
	logic       pend_valid;   // character waiting behind an address word
	logic [7:0] pend_char;
	logic       out_free;
	logic       take;
	logic       is_nl;
	logic       wrap;
	logic [7:0] addr_byte;

	assign out_free   = !wr_valid || wr_ready;
	assign char_ready = started && out_free && !pend_valid;
	assign take       = char_valid && char_ready;
	assign is_nl      = (char_data == 8'h0A);
	assign wrap       = !is_nl && (col == 5'(line_cols));

	// address of the line we are about to move to
	assign addr_byte = cmd_set_addr | {1'b0, (line ? 7'h00 : line2_addr)};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			started    <= 1'b0;
			wr_valid   <= 1'b0;
			pend_valid <= 1'b0;
			line       <= 1'b0;
			col        <= '0;
		end else begin
			if (init_start) begin
				started <= 1'b1;
			end
			if (out_free) begin
				if (pend_valid) begin
					wr_valid   <= 1'b1;
					pend_valid <= 1'b0;
				end else begin
					wr_valid   <= take;
					pend_valid <= take && wrap;
				end
			end
			if (init_start) begin    // cursor home after clear
				line <= 1'b0;
				col  <= '0;
			end else if (take) begin
				if (is_nl) begin
					line <= ~line;
					col  <= '0;
				end else if (wrap) begin
					line <= ~line;
					col  <= 5'd1;     // the wrapped char lands in column 0
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			if (pend_valid) begin
				wr_word <= '{rs: 1'b1, data: pend_char};
			end else if (take) begin
				if (is_nl || wrap) begin
					wr_word <= '{rs: 1'b0, data: addr_byte};
				end else begin
					wr_word <= '{rs: 1'b1, data: char_data};
				end
			end
		end
		if (take && wrap) begin
			pend_char <= char_data;
		end
	end

endmodule

//--- lcd_bus_ctrl.sv
`timescale 1ns/1ps

module lcd_bus_ctrl #(
	parameter int clk_per_us = 25
) (
	input  logic               clk,
	input  logic               arst_n,
	input  lcd_pkg::mode_t     mode,
	input  logic               reinit_req,
	output logic               reinit_ack,
	input  logic               rd_valid,
	output logic               rd_ready,
	input  lcd_pkg::bus_word_t rd_word,
	output logic               init_start,
	output logic               init_done,
	output logic               e,
	output logic               rs,
	output logic [7:0]         lcd_data
);

	import lcd_pkg::*;

	localparam int cnt_w = $clog2(t_power_up * clk_per_us + 1);

	// init phase boundaries in us, counted from the first command
	localparam int p_disp  = t_init_pulse + t_wait_func;
	localparam int p_clear = p_disp + t_init_pulse + t_wait_disp;
	localparam int p_entry = p_clear + t_init_pulse + t_wait_clear;
	localparam int p_end   = p_entry + t_init_pulse + t_wait_entry;

	localparam logic [cnt_w-1:0] c_pwr_last  = cnt_w'(t_power_up * clk_per_us - 1);
	localparam logic [cnt_w-1:0] c_pulse     = cnt_w'(t_init_pulse * clk_per_us);
	localparam logic [cnt_w-1:0] c_disp      = cnt_w'(p_disp * clk_per_us);
	localparam logic [cnt_w-1:0] c_clear     = cnt_w'(p_clear * clk_per_us);
	localparam logic [cnt_w-1:0] c_entry     = cnt_w'(p_entry * clk_per_us);
	localparam logic [cnt_w-1:0] c_init_last = cnt_w'(p_end * clk_per_us - 1);
	localparam logic [cnt_w-1:0] c_e_rise    = cnt_w'(t_e_rise * clk_per_us);
	localparam logic [cnt_w-1:0] c_e_fall    = cnt_w'(t_e_fall * clk_per_us);
	localparam logic [cnt_w-1:0] c_hold_last = cnt_w'(t_cmd_total * clk_per_us - 1);

	typedef enum logic [1:0] {
		st_pwr,
		st_init,
		st_idle,
		st_hold
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] cnt_nxt;
	mode_t            mode_q;     // mode frozen for this init run
	logic             init_e;
	logic [7:0]       init_byte;

	assign cnt_nxt  = cnt + 1'b1;
	assign rd_ready = (state == st_idle) && init_done && !reinit_req;

	// init command on the bus for the current count
	always_comb begin
		init_e    = 1'b0;
		init_byte = 8'h00;
		if (cnt < c_pulse) begin
			init_e    = 1'b1;
			init_byte = cmd_func_set | {4'b0, mode_q.lines, mode_q.font, 2'b0};
		end else if (cnt >= c_disp && cnt < c_disp + c_pulse) begin
			init_e    = 1'b1;
			init_byte = cmd_disp_ctrl | {5'b0, mode_q.disp_on, mode_q.cursor_on, mode_q.blink};
		end else if (cnt >= c_clear && cnt < c_clear + c_pulse) begin
			init_e    = 1'b1;
			init_byte = cmd_clear;
		end else if (cnt >= c_entry && cnt < c_entry + c_pulse) begin
			init_e    = 1'b1;
			init_byte = cmd_entry_mode | {6'b0, mode_q.inc_dec, mode_q.shift};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			cnt        <= '0;
			init_done  <= 1'b0;
			init_start <= 1'b0;
			reinit_ack <= 1'b0;
			e          <= 1'b0;
			rs         <= 1'b0;
			lcd_data   <= 8'h00;
		end else begin
			init_start <= 1'b0;
			reinit_ack <= 1'b0;
			e          <= 1'b0;     // pins default low
			rs         <= 1'b0;
			lcd_data   <= 8'h00;
			case (state)
				st_pwr: begin
					if (cnt == c_pwr_last) begin
						cnt   <= '0;
						state <= st_init;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				st_init: begin
					e        <= init_e;
					lcd_data <= init_byte;
					if (cnt == c_init_last) begin
						cnt       <= '0;
						init_done <= 1'b1;
						state     <= st_idle;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				st_idle: begin
					if (reinit_req) begin     // restart, fifo contents stay
						init_done  <= 1'b0;
						init_start <= 1'b1;
						reinit_ack <= 1'b1;
						cnt        <= '0;
						state      <= st_pwr;
					end else if (rd_valid && rd_ready) begin
						rs       <= rd_word.rs;
						lcd_data <= rd_word.data;
						cnt      <= '0;
						state    <= st_hold;
					end
				end
				st_hold: begin
					if (cnt == c_hold_last) begin
						cnt   <= '0;
						state <= st_idle;
					end else begin
						rs       <= rs;     // word held for the whole slot
						lcd_data <= lcd_data;
						e        <= (cnt_nxt >= c_e_rise) && (cnt_nxt < c_e_fall);
						cnt      <= cnt_nxt;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && reinit_req) begin
			mode_q <= mode;
		end
	end

endmodule

//--- lcd_top.sv
`timescale 1ns/1ps

module lcd_top #(
	parameter int clk_per_us = 25,
	parameter int fifo_depth = 8
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           char_valid,
	output logic           char_ready,
	input  logic [7:0]     char_data,
	input  logic           cfg_we,
	input  lcd_pkg::mode_t cfg_wdata,
	output logic           init_done,
	output logic           e,
	output logic           rs,
	output logic [7:0]     lcd_data
);

	import lcd_pkg::*;

	mode_t     mode;
	logic      reinit_req;
	logic      reinit_ack;
	logic      init_start;
	logic      wr_valid;
	logic      wr_ready;
	bus_word_t wr_word;
	logic      rd_valid;
	logic      rd_ready;
	bus_word_t rd_word;

	lcd_cfg_regs u_cfg (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg_we     (cfg_we),
		.cfg_wdata  (cfg_wdata),
		.reinit_ack (reinit_ack),
		.mode       (mode),
		.reinit_req (reinit_req)
	);

	lcd_text_writer u_writer (
		.clk        (clk),
		.arst_n     (arst_n),
		.init_start (init_start),
		.char_valid (char_valid),
		.char_ready (char_ready),
		.char_data  (char_data),
		.wr_valid   (wr_valid),
		.wr_ready   (wr_ready),
		.wr_word    (wr_word)
	);

	lcd_cmd_fifo #(
		.width (bus_word_w),
		.depth (fifo_depth)
	) u_fifo (
		.clk      (clk),
		.arst_n   (arst_n),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr_data  (wr_word),
		.rd_valid (rd_valid),
		.rd_ready (rd_ready),
		.rd_data  (rd_word)
	);

	lcd_bus_ctrl #(
		.clk_per_us (clk_per_us)
	) u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.mode       (mode),
		.reinit_req (reinit_req),
		.reinit_ack (reinit_ack),
		.rd_valid   (rd_valid),
		.rd_ready   (rd_ready),
		.rd_word    (rd_word),
		.init_start (init_start),
		.init_done  (init_done),
		.e          (e),
		.rs         (rs),
		.lcd_data   (lcd_data)
	);

endmodule

//--- tb_lcd_top.sv
`timescale 1ns/1ps

module tb_lcd_top;

	import lcd_pkg::*;

	localparam int clk_per_us     = 2;
	localparam int fifo_depth     = 4;
	localparam int init_e_len     = t_init_pulse * clk_per_us;
	localparam int word_e_len     = (t_e_fall - t_e_rise) * clk_per_us;
	localparam int timeout_cycles = 2 * (2 * 960) + 60 * 100 + 2000;

	logic       clk;
	logic       arst_n;
	logic       char_valid;
	logic       char_ready;
	logic [7:0] char_data;
	logic       cfg_we;
	mode_t      cfg_wdata;
	logic       init_done;
	logic       e;
	logic       rs;
	logic [7:0] lcd_data;

	logic [8:0] exp_q[$];        // expected {rs, data}
	int         exp_len_q[$];    // expected e high cycles
	logic [8:0] got_q[$];
	int         got_len_q[$];
	logic       ref_line;
	int         ref_col;
	logic [8:0] cur_word;
	int         hi_cnt;
	logic       e_prev;
	logic       ready_low_seen;
	int         cycle_cnt;
	logic [7:0] txt[$];
	mode_t      new_mode;

	lcd_top #(
		.clk_per_us (clk_per_us),
		.fifo_depth (fifo_depth)
	) dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.char_valid (char_valid),
		.char_ready (char_ready),
		.char_data  (char_data),
		.cfg_we     (cfg_we),
		.cfg_wdata  (cfg_wdata),
		.init_done  (init_done),
		.e          (e),
		.rs         (rs),
		.lcd_data   (lcd_data)
	);

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	// expected bus words for an optional init and a text
	function automatic void expect_words(input bit with_init, input mode_t m,
			input logic [7:0] t[$]);
		if (with_init) begin
			exp_q.push_back({1'b0, cmd_func_set | {4'b0, m.lines, m.font, 2'b0}});
			exp_q.push_back({1'b0, cmd_disp_ctrl | {5'b0, m.disp_on, m.cursor_on, m.blink}});
			exp_q.push_back({1'b0, cmd_clear});
			exp_q.push_back({1'b0, cmd_entry_mode | {6'b0, m.inc_dec, m.shift}});
			repeat (4) exp_len_q.push_back(init_e_len);
			ref_line = 1'b0;    // clear homes the cursor
			ref_col  = 0;
		end
		foreach (t[i]) begin
			if (t[i] == 8'h0A || ref_col == line_cols) begin
				ref_line = ~ref_line;
				exp_q.push_back({1'b0, cmd_set_addr | (ref_line ? {1'b0, line2_addr} : 8'h00)});
				exp_len_q.push_back(word_e_len);
				ref_col = 0;
			end
			if (t[i] != 8'h0A) begin
				exp_q.push_back({1'b1, t[i]});
				exp_len_q.push_back(word_e_len);
				ref_col++;
			end
		end
	endfunction

	function automatic void load_text(input string s);
		txt.delete();
		for (int i = 0; i < s.len(); i++) begin
			txt.push_back(s[i]);
		end
	endfunction

	function automatic void load_random(input int n);
		txt.delete();
		repeat (n) txt.push_back(8'($urandom_range(8'h7E, 8'h20)));    // printable only
	endfunction

	// starts and ends on a falling edge
	task automatic send_byte(input logic [7:0] c);
		char_valid = 1'b1;
		char_data  = c;
		while (!char_ready) begin
			ready_low_seen = 1'b1;
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic send_text(input logic [7:0] t[$], input int max_gap);
		@(negedge clk);
		foreach (t[i]) begin
			if (max_gap > 0) begin
				char_valid = 1'b0;
				repeat ($urandom_range(max_gap)) @(negedge clk);
			end
			send_byte(t[i]);
		end
		char_valid = 1'b0;
	endtask

	// one word per falling edge of e
	always @(negedge clk) begin
		if (e) begin
			cur_word = {rs, lcd_data};
			hi_cnt   = hi_cnt + 1;
		end else if (e_prev) begin
			got_q.push_back(cur_word);
			got_len_q.push_back(hi_cnt);
			hi_cnt = 0;
		end
		e_prev = e;
	end

	always @(posedge clk) begin
		while (got_q.size() != 0) begin
			assert (exp_q.size() != 0) else stop_with_failure("unexpected word on the LCD bus");
			assert (got_q[0] == exp_q[0]) else begin
				$display("[ERROR] e_word expected %h got %h", exp_q[0], got_q[0]);
				stop_with_failure("wrong word on the LCD bus");
			end
			assert (got_len_q[0] == exp_len_q[0]) else begin
				$display("[ERROR] e_high_cycles expected %h got %h", exp_len_q[0], got_len_q[0]);
				stop_with_failure("wrong enable pulse width");
			end
			void'(got_q.pop_front());
			void'(got_len_q.pop_front());
			void'(exp_q.pop_front());
			void'(exp_len_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			stop_with_failure("timeout, the LCD words did not all arrive in time");
		end
	end

	initial begin
		void'($urandom(80));
		clk            = 1'b0;
		arst_n         = 1'b0;
		char_valid     = 1'b0;
		char_data      = 8'h00;
		cfg_we         = 1'b0;
		cfg_wdata      = '0;
		hi_cnt         = 0;
		e_prev         = 1'b0;
		ready_low_seen = 1'b0;
		cycle_cnt      = 0;
		txt.delete();
		expect_words(1'b1, 7'h3C, txt);    // reset mode
		repeat (3) @(negedge clk);
		assert (!e && !rs && lcd_data == 8'h00 && !init_done && !char_ready) else
			stop_with_failure("outputs not low during reset");
		arst_n = 1'b1;

		while (exp_q.size() != 0) @(negedge clk);
		while (!init_done) @(negedge clk);

		load_text("Hello\n\n");    // newlines give c0 then 80
		expect_words(1'b0, '0, txt);
		send_text(txt, 3);

		load_random(33);    // wraps to line 2 and back to line 1
		expect_words(1'b0, '0, txt);
		send_text(txt, 2);

		load_random(8);    // burst past the fifo depth
		expect_words(1'b0, '0, txt);
		ready_low_seen = 1'b0;
		send_text(txt, 0);
		assert (ready_low_seen) else stop_with_failure("char_ready never dropped in the burst");

		// reconfigure while the last word is still on the pins
		new_mode = 7'($urandom_range(7'h7F));
		load_random(17);
		while (!(exp_q.size() == 1 && e)) @(negedge clk);
		expect_words(1'b1, new_mode, txt);
		cfg_we    = 1'b1;
		cfg_wdata = new_mode;
		@(negedge clk);
		cfg_we = 1'b0;
		while (init_done) @(negedge clk);
		send_text(txt, 2);
		while (exp_q.size() != 0) @(negedge clk);
		repeat (200) @(negedge clk);    // catch stray words

		$display("all tests passed");
		$finish;
	end

endmodule

//--- sources.f
lcd_pkg.sv
lcd_cfg_regs.sv
lcd_cmd_fifo.sv
lcd_text_writer.sv
lcd_bus_ctrl.sv
lcd_top.sv
tb_lcd_top.sv

//--- Bender.yml
package:
  name: lcd_top

sources:
  - lcd_pkg.sv
  - lcd_cfg_regs.sv
  - lcd_cmd_fifo.sv
  - lcd_text_writer.sv
  - lcd_bus_ctrl.sv
  - lcd_top.sv
  - target: test
    files:
      - tb_lcd_top.sv
